/* dv/measure_core_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module measure_core_tb;
  import measure_pkg::*;

  logic     gmii_tx_clk;
  logic     sys_rst;
  logic     sec_oneshot;
  stamp_t   global_counter;
  rx_beat_t rx_in;
  byte_t    gmii_txd;
  logic     gmii_tx_en;
  stamp_t   rx_pps;
  stamp_t   rx_throughput;
  stamp_t   rx_latency;

  logic [31:0] lfsr;
  int          checks;
  int          errors;
  int          bursts;
  stamp_t      decide_g;       // global_counter on the OFS_DECIDE beat
  byte_t       frm[$];         // Frame being driven
  byte_t       ref_frame[$];   // Expected reply burst
  byte_t       cur_burst[$];   // Burst seen on GMII
  logic [79:0] req_q[$];       // Requests sent, {mac, ip}
  logic [79:0] reply_q[$];     // Replies seen, {mac, ip}

  measure_core i_measure_core (
    .gmii_tx_clk    (gmii_tx_clk),
    .sys_rst        (sys_rst),
    .sec_oneshot    (sec_oneshot),
    .global_counter (global_counter),
    .rx_in          (rx_in),
    .gmii_txd       (gmii_txd),
    .gmii_tx_en     (gmii_tx_en),
    .rx_pps         (rx_pps),
    .rx_throughput  (rx_throughput),
    .rx_latency     (rx_latency)
  );

  always #20 gmii_tx_clk = ~gmii_tx_clk;

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};  // x^32+x^22+x^2+x+1
      r    = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  task automatic check_value(input string name, input logic [79:0] expected,
                             input logic [79:0] actual);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
    end
  endtask

  task automatic next_cycle();
    @(posedge gmii_tx_clk);
    #2;
    global_counter = global_counter + 1;  // Free-running time base
  endtask

  task automatic frm_field(input logic [47:0] v, input int n);
    for (int i = n - 1; i >= 0; i--) frm.push_back(v[8*i +: 8]);
  endtask

  task automatic ref_field(input logic [47:0] v, input int n);
    for (int i = n - 1; i >= 0; i--) ref_frame.push_back(v[8*i +: 8]);
  endtask

  // --------------------------------------------------
  // Frame builders and driver
  // --------------------------------------------------
  task automatic build_random(input int len);
    frm.delete();
    for (int i = 0; i < len; i++) frm.push_back(8'(rand_bits(8)));
    frm[12] = 8'h08;  // IPv4 type, never ARP
    frm[13] = 8'h00;
  endtask

  task automatic build_test(input stamp_t stamp);
    build_random(64);
    for (int i = 0; i < 5; i++) frm[42 + i] = MAGIC_CODE[8*(4-i) +: 8];
    for (int i = 0; i < 4; i++) frm[47 + i] = stamp[8*(3-i) +: 8];
  endtask

  task automatic build_arp(input mac_t mac, input ipv4_t sip, input ipv4_t tip,
                           input logic [15:0] op, input int len);
    frm.delete();
    frm_field(48'hffff_ffff_ffff, 6);
    frm_field(mac, 6);
    frm_field(16'h0806, 2);
    frm_field(16'h0001, 2);
    frm_field(16'h0800, 2);
    frm_field(8'd6, 1);
    frm_field(8'd4, 1);
    frm_field(op, 2);
    frm_field(mac, 6);
    frm_field(sip, 4);
    frm_field(48'h0, 6);
    frm_field(tip, 4);
    while (frm.size() < len) frm.push_back(8'h00);
  endtask

  task automatic send_frame(input int gap);
    for (int i = 0; i < frm.size(); i++) begin
      next_cycle();
      rx_in = '{valid: 1'b1, in_frame: 1'b1, data: frm[i]};
      if (i == OFS_DECIDE) decide_g = global_counter;
    end
    next_cycle();
    rx_in = '{valid: 1'b1, in_frame: 1'b0, data: 8'h00};  // End beat
    next_cycle();
    rx_in = '0;
    repeat (gap) next_cycle();
  endtask

  task automatic pulse_second();
    next_cycle();
    sec_oneshot = 1'b1;
    next_cycle();
    sec_oneshot = 1'b0;
  endtask

  task automatic random_request(output mac_t mac, output ipv4_t ip);
    mac[47:40] = 8'h02;
    mac[39:32] = 8'(rand_bits(8));
    mac[31:0]  = rand_bits(32);
    ip         = {8'd10, 8'd0, 8'd21, 8'(rand_bits(8))};
    build_arp(mac, ip, OWN_IPV4, 16'd1, 52);
    req_q.push_back({mac, ip});
  endtask

  task automatic wait_replies(input int n, input int limit);
    int cnt;
    cnt = 0;
    while (reply_q.size() < n && cnt < limit) begin
      next_cycle();
      cnt++;
    end
    assert (reply_q.size() >= n) else begin
      errors++;
      $display("Timeout: only %0d of %0d replies seen in %0d cycles", reply_q.size(), n, limit);
    end
  endtask

  task automatic wait_quiet(input int quiet, input int limit);
    int idle;
    int cnt;
    idle = 0;
    cnt  = 0;
    while (idle < quiet && cnt < limit) begin
      next_cycle();
      idle = gmii_tx_en ? 0 : idle + 1;
      cnt++;
    end
    assert (idle >= quiet) else begin
      errors++;
      $display("Timeout: transmitter did not go quiet within %0d cycles", limit);
    end
  endtask

  // --------------------------------------------------
  // GMII monitor
  // --------------------------------------------------
  task automatic build_reply(input mac_t mac, input ipv4_t ip);
    logic [31:0] c;
    ref_frame.delete();
    repeat (7) ref_frame.push_back(8'h55);
    ref_frame.push_back(8'hd5);
    ref_field(mac, 6);
    ref_field(OWN_MAC, 6);
    ref_field(16'h0806, 2);
    ref_field(16'h0001, 2);
    ref_field(16'h0800, 2);
    ref_field(8'd6, 1);
    ref_field(8'd4, 1);
    ref_field(16'd2, 2);
    ref_field(OWN_MAC, 6);
    ref_field(OWN_IPV4, 4);
    ref_field(mac, 6);
    ref_field(ip, 4);
    while (ref_frame.size() < 68) ref_frame.push_back(8'h00);
    c = 32'hffffffff;
    for (int i = 8; i < 68; i++) begin
      c = c ^ {24'h0, ref_frame[i]};
      repeat (8) c = (c >> 1) ^ (32'hedb88320 & {32{c[0]}});
    end
    c = ~c;
    for (int i = 0; i < 4; i++) ref_frame.push_back(c[8*i +: 8]);  // LSB first
  endtask

  task automatic check_burst();
    mac_t  mac;
    ipv4_t ip;
    bursts++;
    check_value("burst_length", TX_FRAME_BYTES, cur_burst.size());
    if (cur_burst.size() == TX_FRAME_BYTES) begin
      for (int i = 0; i < 6; i++) mac = {mac[39:0], cur_burst[8 + i]};
      for (int i = 0; i < 4; i++) ip = {ip[23:0], cur_burst[46 + i]};
      build_reply(mac, ip);
      for (int i = 0; i < TX_FRAME_BYTES; i++) begin
        check_value($sformatf("reply_byte_%0d", i), ref_frame[i], cur_burst[i]);
      end
      reply_q.push_back({mac, ip});
    end
  endtask

  always @(negedge gmii_tx_clk) begin
    if (gmii_tx_en === 1'b1) begin
      cur_burst.push_back(gmii_txd);
    end else if (cur_burst.size() != 0) begin
      check_burst();
      cur_burst.delete();
    end
  end

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------
  initial begin
    stamp_t stamp;
    mac_t   mac;
    ipv4_t  ip;
    int     n;
    int     len;
    int     total;
    int     base;
    int     j;
    gmii_tx_clk    = 1'b0;
    sys_rst        = 1'b1;
    sec_oneshot    = 1'b0;
    global_counter = '0;
    rx_in          = '0;
    lfsr           = 32'h6a0b6cb0;
    checks         = 0;
    errors         = 0;
    bursts         = 0;
    repeat (3) next_cycle();
    sys_rst = 1'b0;
    repeat (4) next_cycle();

    for (int t = 0; t < 3; t++) begin  // Latency frames
      stamp = rand_bits(32);
      build_test(stamp);
      send_frame(4);
      check_value("latency", stamp_t'(decide_g - stamp), rx_latency);
    end

    pulse_second();  // Opens a clean window
    n     = 3 + rand_bits(2);
    total = 0;
    for (int f = 0; f < n; f++) begin
      len = 60 + rand_bits(5);
      build_random(len);
      send_frame(1 + rand_bits(3));
      total += len;
    end
    pulse_second();
    check_value("rx_pps", n, rx_pps);
    check_value("rx_throughput", total, rx_throughput);

    req_q.delete();  // Spaced requests
    reply_q.delete();
    for (int r = 0; r < 3; r++) begin
      random_request(mac, ip);
      send_frame(80);
    end
    wait_replies(3, 2000);
    wait_quiet(150, 3000);
    check_value("spaced_reply_count", 3, reply_q.size());
    for (int r = 0; r < reply_q.size() && r < 3; r++) begin
      check_value($sformatf("spaced_reply_%0d", r), req_q[r], reply_q[r]);
    end

    base = bursts;  // Frames that must stay silent
    build_arp(48'h02_11_22_33_44_55, 32'h0a00_1501, 32'h0a00_156a, 16'd1, 60);
    send_frame(3);
    build_arp(48'h02_11_22_33_44_56, 32'h0a00_1502, OWN_IPV4, 16'd2, 60);
    send_frame(3);
    build_random(64);
    send_frame(3);
    build_random(72);
    send_frame(3);
    wait_quiet(150, 3000);
    check_value("ignored_bursts", 0, bursts - base);

    req_q.delete();  // Back-to-back requests
    reply_q.delete();
    for (int r = 0; r < 6; r++) begin
      random_request(mac, ip);
      send_frame(0);
    end
    wait_replies(ARP_QUEUE_DEPTH, 2000);
    wait_quiet(150, 5000);
    checks++;
    assert (reply_q.size() >= ARP_QUEUE_DEPTH && reply_q.size() <= 6) else begin
      errors++;
      $display("CHECK FAILED burst_reply_count expected %0d..6 actual %0d",
               ARP_QUEUE_DEPTH, reply_q.size());
    end
    j = 0;
    foreach (reply_q[r]) begin
      while (j < req_q.size() && req_q[j] != reply_q[r]) j++;
      checks++;
      assert (j < req_q.size()) else begin
        errors++;
        $display("Reply %0d does not match any later request in order", r);
      end
      j++;
    end

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* source/arp_reply_tx.sv */
`timescale 1ns/100ps
`default_nettype none

module arp_reply_tx (
  input  wire logic                   gmii_tx_clk,
  input  wire logic                   sys_rst,
  input  wire measure_pkg::arp_req_t  head,
  input  wire measure_pkg::stamp_t    crc_out,
  output logic                        pop,
  output measure_pkg::byte_t          gmii_txd,
  output logic                        gmii_tx_en,
  output logic                        crc_init,
  output logic                        crc_en,
  output measure_pkg::byte_t          crc_data
);
  import measure_pkg::*;

  logic [TX_COUNT_W-1:0] tx_cnt;  // Index of the next byte to send
  mac_t                  dst_mac;
  ipv4_t                 dst_ip;
  arp_frame_t            reply;
  byte_t                 tx_byte;
  logic                  in_body;

  assign pop = ~gmii_tx_en & head.valid;  // Leaves one idle cycle between frames

  // --------------------------------------------------
  // Reply content
  // --------------------------------------------------
  assign reply = '{
    eth_dst:  dst_mac,
    eth_src:  OWN_MAC,
    eth_type: ETH_TYPE_ARP,
    htype:    ARP_HW_ETHER,
    ptype:    ETH_TYPE_IPV4,
    hlen:     8'd6,
    plen:     8'd4,
    oper:     ARP_OP_REPLY,
    sha:      OWN_MAC,
    spa:      OWN_IPV4,
    tha:      dst_mac,
    tpa:      dst_ip
  };

  always_comb begin
    int unsigned idx;
    idx = tx_cnt;
    if (idx < TX_BODY_START - 1) begin
      tx_byte = PREAMBLE_BYTE;
    end else if (idx == TX_BODY_START - 1) begin
      tx_byte = SFD_BYTE;
    end else if (idx < TX_BODY_START + ARP_HDR_BYTES) begin
      tx_byte = reply[$bits(arp_frame_t) - 1 - 8 * (idx - TX_BODY_START) -: 8];
    end else if (idx < TX_FCS_START) begin
      tx_byte = 8'h00;  // Pad to minimum size
    end else if (idx < TX_FRAME_BYTES) begin
      tx_byte = crc_out[31 - 8 * (idx - TX_FCS_START) -: 8];
    end else begin
      tx_byte = 8'h00;
    end
  end

  // CRC sees each body byte as it is registered into gmii_txd
  assign in_body  = gmii_tx_en && (tx_cnt >= TX_BODY_START) && (tx_cnt < TX_FCS_START);
  assign crc_en   = in_body;
  assign crc_init = gmii_tx_en && (tx_cnt == TX_BODY_START);
  assign crc_data = tx_byte;

  // --------------------------------------------------
  // Sequencer
  // --------------------------------------------------
  always_ff @(posedge gmii_tx_clk) begin
    if (sys_rst) begin
      gmii_tx_en <= 1'b0;
      tx_cnt     <= '0;
    end else if (pop) begin
      gmii_tx_en <= 1'b1;
      tx_cnt     <= TX_COUNT_W'(1);
    end else if (gmii_tx_en) begin
      if (tx_cnt == TX_COUNT_W'(TX_FRAME_BYTES)) begin
        gmii_tx_en <= 1'b0;  // Last FCS byte done
      end else begin
        tx_cnt <= tx_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge gmii_tx_clk) begin
    if (pop) begin
      dst_mac  <= head.dst_mac;
      dst_ip   <= head.dst_ip;
      gmii_txd <= PREAMBLE_BYTE;
    end else if (gmii_tx_en && (tx_cnt < TX_COUNT_W'(TX_FRAME_BYTES))) begin
      gmii_txd <= tx_byte;
    end else begin
      gmii_txd <= 8'h00;
    end
  end

endmodule

`default_nettype wire

/* source/arp_req_fifo.sv */
`timescale 1ns/100ps
`default_nettype none

module arp_req_fifo (
  input  wire logic                   gmii_tx_clk,
  input  wire logic                   sys_rst,
  input  wire measure_pkg::arp_req_t  arp_req,
  input  wire logic                   pop,
  output measure_pkg::arp_req_t       head,
  output logic                        credit_return
);
  import measure_pkg::*;

  arp_req_t               mem [ARP_QUEUE_DEPTH];
  logic [QUEUE_PTR_W-1:0] wr_ptr;
  logic [QUEUE_PTR_W-1:0] rd_ptr;
  logic [QUEUE_CNT_W-1:0] count;
  logic                   pop_ok;

  function automatic logic [QUEUE_PTR_W-1:0] ptr_next(input logic [QUEUE_PTR_W-1:0] p);
    return (p == QUEUE_PTR_W'(ARP_QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign pop_ok        = pop & (count != '0);
  assign credit_return = pop_ok;  // One credit per released entry

  always_ff @(posedge gmii_tx_clk) begin
    if (arp_req.valid) mem[wr_ptr] <= arp_req;
  end

  always_ff @(posedge gmii_tx_clk) begin
    if (sys_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (arp_req.valid) wr_ptr <= ptr_next(wr_ptr);
      if (pop_ok)        rd_ptr <= ptr_next(rd_ptr);
      case ({arp_req.valid, pop_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign head = '{valid: (count != '0), dst_mac: mem[rd_ptr].dst_mac, dst_ip: mem[rd_ptr].dst_ip};

endmodule

`default_nettype wire

/* source/crc32_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module crc32_gen (
  input  wire logic                gmii_tx_clk,
  input  wire logic                sys_rst,
  input  wire logic                crc_init,
  input  wire logic                crc_en,
  input  wire measure_pkg::byte_t  crc_data,
  output measure_pkg::stamp_t      crc_out
);
  import measure_pkg::*;

  logic [31:0] crc_q;
  logic [31:0] crc_base;

  // One byte through the reflected polynomial, LSB first
  function automatic logic [31:0] crc_byte(input logic [31:0] c, input byte_t d);
    logic [31:0] r;
    logic        fb;
    r = c;
    for (int i = 0; i < 8; i++) begin
      fb = r[0] ^ d[i];
      r  = r >> 1;
      if (fb) r = r ^ CRC_POLY_REF;
    end
    return r;
  endfunction

  assign crc_base = crc_init ? CRC_PRESET : crc_q;  // Init restarts on this byte

  always_ff @(posedge gmii_tx_clk) begin
    if (sys_rst) begin
      crc_q <= CRC_PRESET;
    end else if (crc_en) begin
      crc_q <= crc_byte(crc_base, crc_data);
    end else if (crc_init) begin
      crc_q <= CRC_PRESET;
    end
  end

  // Complemented, low byte goes out first
  assign crc_out = ~{crc_q[7:0], crc_q[15:8], crc_q[23:16], crc_q[31:24]};

endmodule

`default_nettype wire

/* source/measure_core.sv */
`timescale 1ns/100ps
`default_nettype none

module measure_core (
  input  wire logic                   gmii_tx_clk,
  input  wire logic                   sys_rst,
  input  wire logic                   sec_oneshot,
  input  wire measure_pkg::stamp_t    global_counter,
  input  wire measure_pkg::rx_beat_t  rx_in,
  output measure_pkg::byte_t          gmii_txd,
  output logic                        gmii_tx_en,
  output measure_pkg::stamp_t         rx_pps,
  output measure_pkg::stamp_t         rx_throughput,
  output measure_pkg::stamp_t         rx_latency
);
  import measure_pkg::*;

  frame_stat_t frame_stat;
  arp_req_t    arp_req;
  arp_req_t    head;
  logic        pop;
  logic        credit_return;
  stamp_t      crc_out;
  logic        crc_init;
  logic        crc_en;
  byte_t       crc_data;

  // --------------------------------------------------
  // Receive side
  // --------------------------------------------------
  rx_frame_parser i_rx_frame_parser (
    .gmii_tx_clk    (gmii_tx_clk),
    .sys_rst        (sys_rst),
    .rx_in          (rx_in),
    .global_counter (global_counter),
    .credit_return  (credit_return),
    .frame_stat     (frame_stat),
    .arp_req        (arp_req),
    .rx_latency     (rx_latency)
  );

  rx_rate_counter i_rx_rate_counter (
    .gmii_tx_clk   (gmii_tx_clk),
    .sys_rst       (sys_rst),
    .sec_oneshot   (sec_oneshot),
    .frame_stat    (frame_stat),
    .rx_pps        (rx_pps),
    .rx_throughput (rx_throughput)
  );

  // --------------------------------------------------
  // ARP reply path
  // --------------------------------------------------
  arp_req_fifo i_arp_req_fifo (
    .gmii_tx_clk   (gmii_tx_clk),
    .sys_rst       (sys_rst),
    .arp_req       (arp_req),
    .pop           (pop),
    .head          (head),
    .credit_return (credit_return)
  );

  arp_reply_tx i_arp_reply_tx (
    .gmii_tx_clk (gmii_tx_clk),
    .sys_rst     (sys_rst),
    .head        (head),
    .crc_out     (crc_out),
    .pop         (pop),
    .gmii_txd    (gmii_txd),
    .gmii_tx_en  (gmii_tx_en),
    .crc_init    (crc_init),
    .crc_en      (crc_en),
    .crc_data    (crc_data)
  );

  crc32_gen i_crc32_gen (
    .gmii_tx_clk (gmii_tx_clk),
    .sys_rst     (sys_rst),
    .crc_init    (crc_init),
    .crc_en      (crc_en),
    .crc_data    (crc_data),
    .crc_out     (crc_out)
  );

endmodule

`default_nettype wire

/* source/measure_pkg.sv */
`default_nettype none

package measure_pkg;

  // --------------------------------------------------
  // Basic types
  // --------------------------------------------------
  typedef logic [7:0]  byte_t;
  typedef logic [47:0] mac_t;
  typedef logic [31:0] ipv4_t;
  typedef logic [31:0] stamp_t;

  typedef struct packed {
    logic  valid;
    logic  in_frame;   // Low on a valid beat closes the frame
    byte_t data;
  } rx_beat_t;

  typedef struct packed {
    logic        done;
    logic [15:0] length;  // Bytes in the frame
  } frame_stat_t;

  typedef struct packed {
    logic  valid;
    mac_t  dst_mac;
    ipv4_t dst_ip;
  } arp_req_t;

  // Reply layout after the SFD, up to the padding
  typedef struct packed {
    mac_t        eth_dst;
    mac_t        eth_src;
    logic [15:0] eth_type;
    logic [15:0] htype;
    logic [15:0] ptype;
    byte_t       hlen;
    byte_t       plen;
    logic [15:0] oper;
    mac_t        sha;
    ipv4_t       spa;
    mac_t        tha;
    ipv4_t       tpa;
  } arp_frame_t;

  // --------------------------------------------------
  // Own addresses and protocol constants
  // --------------------------------------------------
  localparam mac_t  OWN_MAC  = 48'h003776_000101;
  localparam ipv4_t OWN_IPV4 = {8'd10, 8'd0, 8'd21, 8'd105};
  localparam logic [39:0] MAGIC_CODE = 40'hcc_55_aa_33_0f;

  localparam logic [15:0] ETH_TYPE_ARP   = 16'h0806;
  localparam logic [15:0] ETH_TYPE_IPV4  = 16'h0800;
  localparam logic [15:0] ARP_HW_ETHER   = 16'h0001;
  localparam logic [15:0] ARP_OP_REQUEST = 16'd1;
  localparam logic [15:0] ARP_OP_REPLY   = 16'd2;

  // Receive offsets, byte 0 is the first destination MAC byte
  localparam int unsigned OFS_SRC_MAC    = 6;
  localparam int unsigned OFS_TYPE       = 12;
  localparam int unsigned OFS_OPCODE     = 20;
  localparam int unsigned OFS_ARP_SRC_IP = 28;
  localparam int unsigned OFS_ARP_DST_IP = 38;
  localparam int unsigned OFS_MAGIC      = 42;
  localparam int unsigned OFS_STAMP      = 47;
  localparam int unsigned OFS_DECIDE     = 51;

  // Transmit layout
  localparam byte_t       PREAMBLE_BYTE  = 8'h55;
  localparam byte_t       SFD_BYTE       = 8'hd5;
  localparam int unsigned TX_BODY_START  = 8;
  localparam int unsigned TX_BODY_BYTES  = 60;
  localparam int unsigned TX_FCS_START   = TX_BODY_START + TX_BODY_BYTES;
  localparam int unsigned TX_FRAME_BYTES = 72;
  localparam int unsigned TX_COUNT_W     = 7;
  localparam int unsigned ARP_HDR_BYTES  = $bits(arp_frame_t) / 8;

  // CRC-32, reflected form
  localparam logic [31:0] CRC_POLY_REF = 32'hedb88320;
  localparam logic [31:0] CRC_PRESET   = 32'hffffffff;

  // Reply queue
  localparam int unsigned ARP_QUEUE_DEPTH = 2;
  localparam int unsigned QUEUE_CNT_W     = $clog2(ARP_QUEUE_DEPTH + 1);
  localparam int unsigned QUEUE_PTR_W     = (ARP_QUEUE_DEPTH > 1) ? $clog2(ARP_QUEUE_DEPTH) : 1;

endpackage

`default_nettype wire

/* source/rx_frame_parser.sv */
`timescale 1ns/100ps
`default_nettype none

module rx_frame_parser (
  input  wire logic                    gmii_tx_clk,
  input  wire logic                    sys_rst,
  input  wire measure_pkg::rx_beat_t   rx_in,
  input  wire measure_pkg::stamp_t     global_counter,
  input  wire logic                    credit_return,
  output measure_pkg::frame_stat_t     frame_stat,
  output measure_pkg::arp_req_t        arp_req,
  output measure_pkg::stamp_t          rx_latency
);
  import measure_pkg::*;

  logic [15:0]            byte_cnt;
  logic                   beat_byte;
  logic                   beat_end;
  logic                   decide;
  logic                   arp_hit;
  logic                   take;
  logic [QUEUE_CNT_W-1:0] credits;

  mac_t        rx_src_mac;
  logic [15:0] rx_type;
  logic [15:0] rx_opcode;
  ipv4_t       rx_arp_src_ip;
  ipv4_t       rx_arp_dst_ip;
  logic [39:0] rx_magic;
  stamp_t      rx_stamp;

  logic        stat_done;
  logic [15:0] stat_len;
  logic        req_valid;
  mac_t        req_mac;
  ipv4_t       req_ip;

  function automatic logic in_field(input logic [15:0] idx, input int unsigned ofs,
                                    input int unsigned len);
    return (idx >= ofs) && (idx < ofs + len);
  endfunction

  assign beat_byte = rx_in.valid & rx_in.in_frame;
  assign beat_end  = rx_in.valid & ~rx_in.in_frame;
  assign decide    = beat_byte && (byte_cnt == OFS_DECIDE);

  assign arp_hit = decide && (rx_magic != MAGIC_CODE) && (rx_type == ETH_TYPE_ARP) &&
                   (rx_opcode == ARP_OP_REQUEST) && (rx_arp_dst_ip == OWN_IPV4);
  assign take    = arp_hit && (credits != '0);  // No credit, reply is dropped

  // --------------------------------------------------
  // Header field capture
  // --------------------------------------------------
  always_ff @(posedge gmii_tx_clk) begin
    if (beat_byte) begin
      if (in_field(byte_cnt, OFS_SRC_MAC, 6))    rx_src_mac    <= {rx_src_mac[39:0], rx_in.data};
      if (in_field(byte_cnt, OFS_TYPE, 2))       rx_type       <= {rx_type[7:0], rx_in.data};
      if (in_field(byte_cnt, OFS_OPCODE, 2))     rx_opcode     <= {rx_opcode[7:0], rx_in.data};
      if (in_field(byte_cnt, OFS_ARP_SRC_IP, 4)) rx_arp_src_ip <= {rx_arp_src_ip[23:0], rx_in.data};
      if (in_field(byte_cnt, OFS_ARP_DST_IP, 4)) rx_arp_dst_ip <= {rx_arp_dst_ip[23:0], rx_in.data};
      if (in_field(byte_cnt, OFS_MAGIC, 5))      rx_magic      <= {rx_magic[31:0], rx_in.data};
      if (in_field(byte_cnt, OFS_STAMP, 4))      rx_stamp      <= {rx_stamp[23:0], rx_in.data};
    end
  end

  // --------------------------------------------------
  // Counting, decision and credits
  // --------------------------------------------------
  always_ff @(posedge gmii_tx_clk) begin
    if (sys_rst) begin
      byte_cnt   <= '0;
      stat_done  <= 1'b0;
      req_valid  <= 1'b0;
      rx_latency <= '0;
      credits    <= QUEUE_CNT_W'(ARP_QUEUE_DEPTH);
    end else begin
      stat_done <= beat_end && (byte_cnt != '0);  // Empty frames are not counted
      req_valid <= take;
      if (beat_end) begin
        byte_cnt <= '0;
      end else if (beat_byte) begin
        byte_cnt <= byte_cnt + 16'd1;
      end
      if (decide && (rx_magic == MAGIC_CODE)) begin
        rx_latency <= global_counter - rx_stamp;
      end
      case ({take, credit_return})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  always_ff @(posedge gmii_tx_clk) begin
    if (beat_end) stat_len <= byte_cnt;
    if (take) begin
      req_mac <= rx_src_mac;     // Requester becomes the target
      req_ip  <= rx_arp_src_ip;
    end
  end

  assign frame_stat = '{done: stat_done, length: stat_len};
  assign arp_req    = '{valid: req_valid, dst_mac: req_mac, dst_ip: req_ip};

endmodule

`default_nettype wire

/* source/rx_rate_counter.sv */
`timescale 1ns/100ps
`default_nettype none

module rx_rate_counter (
  input  wire logic                      gmii_tx_clk,
  input  wire logic                      sys_rst,
  input  wire logic                      sec_oneshot,
  input  wire measure_pkg::frame_stat_t  frame_stat,
  output measure_pkg::stamp_t            rx_pps,
  output measure_pkg::stamp_t            rx_throughput
);
  import measure_pkg::*;

  stamp_t pkt_acc;
  stamp_t byte_acc;

  always_ff @(posedge gmii_tx_clk) begin
    if (sys_rst) begin
      pkt_acc       <= '0;
      byte_acc      <= '0;
      rx_pps        <= '0;
      rx_throughput <= '0;
    end else if (sec_oneshot) begin
      rx_pps        <= pkt_acc;   // Publish the window
      rx_throughput <= byte_acc;
      pkt_acc       <= '0;
      byte_acc      <= '0;
    end else if (frame_stat.done) begin
      pkt_acc  <= pkt_acc + 32'd1;
      byte_acc <= byte_acc + {16'h0, frame_stat.length};
    end
  end

endmodule

`default_nettype wire

/* src.f */
source/measure_pkg.sv
source/crc32_gen.sv
source/rx_frame_parser.sv
source/rx_rate_counter.sv
source/arp_req_fifo.sv
source/arp_reply_tx.sv
source/measure_core.sv
dv/measure_core_tb.sv
